// File: common/or1k_settings.svh
// Fixed settings for the OR1K integer subset core
// Opcode and sub-opcode values follow the OR1K architecture encoding
// l.sys and l.trap are told apart by bits 25:23 only
// Field ranges are meant to be used as insn[`OR1K_xxx_FIELD]
`ifndef OR1K_SETTINGS_SVH
`define OR1K_SETTINGS_SVH

`define OR1K_RESET_PC     32'h0000_0100

// Instruction fields
`define OR1K_OPC_FIELD    31:26
`define OR1K_RD_FIELD     25:21
`define OR1K_RA_FIELD     20:16
`define OR1K_RB_FIELD     15:11
`define OR1K_IMM_FIELD    15:0
`define OR1K_JBR_FIELD    25:0
`define OR1K_ALU_FIELD    3:0
`define OR1K_SF_FIELD     25:21
`define OR1K_SYS_FIELD    25:23

// Major opcodes
`define OR1K_OPC_J        6'h00
`define OR1K_OPC_JAL      6'h01
`define OR1K_OPC_BNF      6'h03
`define OR1K_OPC_BF       6'h04
`define OR1K_OPC_NOP      6'h05
`define OR1K_OPC_MOVHI    6'h06
`define OR1K_OPC_SYSTRAP  6'h08
`define OR1K_OPC_ADDI     6'h27
`define OR1K_OPC_ANDI     6'h29
`define OR1K_OPC_ORI      6'h2a
`define OR1K_OPC_XORI     6'h2b
`define OR1K_OPC_SFI      6'h2f
`define OR1K_OPC_ALU      6'h38
`define OR1K_OPC_SF       6'h39

// ALU sub-opcodes, insn[3:0] of l.add and friends
`define OR1K_ALU_ADD      4'h0
`define OR1K_ALU_SUB      4'h2
`define OR1K_ALU_AND      4'h3
`define OR1K_ALU_OR       4'h4
`define OR1K_ALU_XOR      4'h5

// Compare codes and sys/trap selectors
`define OR1K_SF_EQ        5'h00
`define OR1K_SF_NE        5'h01
`define OR1K_SYS_CODE     3'b000
`define OR1K_TRAP_CODE    3'b010

`endif

// File: common/or1k_pkg.sv
// Types shared by the OR1K subset core
// Only a 32-bit datapath with 32 registers is supported
package or1k_pkg;

   typedef logic [31:0] insn_t;
   typedef logic [31:0] addr_t;
   typedef logic [31:0] word_t;
   typedef logic [4:0]  rf_addr_t;

   typedef enum logic [2:0] {
      ADD, SUB, AND, OR, XOR, MOVHI, CMP_EQ, CMP_NE
   } alu_op_t;

   // Halt cause, NONE while running
   typedef enum logic [1:0] {
      NONE, ILLEGAL, SYSCALL, TRAP
   } except_t;

   typedef enum logic [1:0] {
      FETCH, EXEC, HALT
   } ctrl_state_t;

   typedef struct packed {
      rf_addr_t    rfa;
      rf_addr_t    rfb;
      rf_addr_t    rfd;
      word_t       immediate;
      logic        imm_sel;
      alu_op_t     alu_op;
      logic        rf_wb;
      logic        setflag;
      logic        jump;
      logic        branch_f;
      logic        branch_nf;
      logic        link;
      logic [25:0] jbr_offset;
      except_t     except;
   } dec_t;

   // Read-only Wishbone classic master request
   typedef struct packed {
      logic  cyc;
      logic  stb;
      addr_t adr;
   } wb_m2s_t;

   // flag is the value after the instruction
   typedef struct packed {
      logic     valid;
      addr_t    pc;
      logic     rf_wb;
      rf_addr_t rd;
      word_t    wdata;
      logic     flag;
   } retire_t;

endpackage

// File: hdl/or1k_decode.sv
// Instruction decoder for the OR1K integer subset, purely combinational
// Loads, stores, SPR access, l.rfe and all other opcodes decode as ILLEGAL
// When except is not NONE the remaining fields carry no meaning
`timescale 1ns/1ns
`include "or1k_settings.svh"

module or1k_decode import or1k_pkg::*; (
   input  insn_t insn_i,
   output dec_t  dec_o
);

   logic [5:0]  opc;
   logic [15:0] imm16;
   word_t       imm_sext;
   word_t       imm_zext;

   assign opc      = insn_i[`OR1K_OPC_FIELD];
   assign imm16    = insn_i[`OR1K_IMM_FIELD];
   assign imm_sext = {{16{imm16[15]}}, imm16};
   assign imm_zext = {16'h0000, imm16};

   always_comb begin
      dec_o            = '0;
      dec_o.rfa        = insn_i[`OR1K_RA_FIELD];
      dec_o.rfb        = insn_i[`OR1K_RB_FIELD];
      dec_o.rfd        = insn_i[`OR1K_RD_FIELD];
      dec_o.jbr_offset = insn_i[`OR1K_JBR_FIELD];
      dec_o.alu_op     = ADD;
      dec_o.except     = NONE;

      case (opc)
         `OR1K_OPC_J:   dec_o.jump = 1'b1;
         `OR1K_OPC_JAL: begin
            dec_o.jump  = 1'b1;
            dec_o.link  = 1'b1;
            dec_o.rf_wb = 1'b1;
            // Link register is always r9
            dec_o.rfd   = 5'd9;
         end
         `OR1K_OPC_BNF: dec_o.branch_nf = 1'b1;
         `OR1K_OPC_BF:  dec_o.branch_f  = 1'b1;
         `OR1K_OPC_NOP: ;
         `OR1K_OPC_MOVHI: begin
            dec_o.immediate = {imm16, 16'h0000};
            dec_o.imm_sel   = 1'b1;
            dec_o.alu_op    = MOVHI;
            dec_o.rf_wb     = 1'b1;
         end
         `OR1K_OPC_ADDI, `OR1K_OPC_ANDI, `OR1K_OPC_ORI, `OR1K_OPC_XORI: begin
            dec_o.imm_sel = 1'b1;
            dec_o.rf_wb   = 1'b1;
            // andi and ori zero-extend, the others sign-extend
            dec_o.immediate = (opc == `OR1K_OPC_ANDI || opc == `OR1K_OPC_ORI) ?
                              imm_zext : imm_sext;
            case (opc)
               `OR1K_OPC_ADDI: dec_o.alu_op = ADD;
               `OR1K_OPC_ANDI: dec_o.alu_op = AND;
               `OR1K_OPC_ORI:  dec_o.alu_op = OR;
               default:        dec_o.alu_op = XOR;
            endcase
         end
         `OR1K_OPC_SF, `OR1K_OPC_SFI: begin
            dec_o.setflag   = 1'b1;
            dec_o.imm_sel   = (opc == `OR1K_OPC_SFI);
            dec_o.immediate = imm_sext;
            case (insn_i[`OR1K_SF_FIELD])
               `OR1K_SF_EQ: dec_o.alu_op = CMP_EQ;
               `OR1K_SF_NE: dec_o.alu_op = CMP_NE;
               default:     dec_o.except = ILLEGAL;
            endcase
         end
         `OR1K_OPC_ALU: begin
            dec_o.rf_wb = 1'b1;
            case (insn_i[`OR1K_ALU_FIELD])
               `OR1K_ALU_ADD: dec_o.alu_op = ADD;
               `OR1K_ALU_SUB: dec_o.alu_op = SUB;
               `OR1K_ALU_AND: dec_o.alu_op = AND;
               `OR1K_ALU_OR:  dec_o.alu_op = OR;
               `OR1K_ALU_XOR: dec_o.alu_op = XOR;
               default: begin
                  dec_o.rf_wb  = 1'b0;
                  dec_o.except = ILLEGAL;
               end
            endcase
         end
         `OR1K_OPC_SYSTRAP: begin
            case (insn_i[`OR1K_SYS_FIELD])
               `OR1K_SYS_CODE:  dec_o.except = SYSCALL;
               `OR1K_TRAP_CODE: dec_o.except = TRAP;
               default:         dec_o.except = ILLEGAL;
            endcase
         end
         default: dec_o.except = ILLEGAL;
      endcase
   end

   // At most one kind of control transfer per instruction
   a_jbr_onehot: assert final ($onehot0({dec_o.jump, dec_o.branch_f, dec_o.branch_nf}));

endmodule

// File: hdl/or1k_alu.sv
// Integer ALU, combinational
// Compares are equality only, as l.sfeq and l.sfne need nothing more
`timescale 1ns/1ns

module or1k_alu import or1k_pkg::*; (
   input  alu_op_t op_i,
   input  word_t   a_i,
   input  word_t   b_i,
   output word_t   result_o,
   output logic    cmp_o
);

   logic equal;

   assign equal = (a_i == b_i);

   always_comb begin
      unique case (op_i)
         ADD:   result_o = a_i + b_i;
         SUB:   result_o = a_i - b_i;
         AND:   result_o = a_i & b_i;
         OR:    result_o = a_i | b_i;
         XOR:   result_o = a_i ^ b_i;
         // b already holds the immediate in the upper half
         MOVHI: result_o = b_i;
         // Setflag ops write no register, difference is only for debug
         CMP_EQ, CMP_NE: result_o = a_i ^ b_i;
      endcase
   end

   // Compare bit, meaningful only for the two CMP ops
   assign cmp_o = (op_i == CMP_NE) ? !equal : equal;

endmodule

// File: hdl/or1k_regfile.sv
// Register file of 32 words with two combinational read ports and one write port
// r0 is cleared at reset and drops writes, so it always reads as zero
`timescale 1ns/1ns

module or1k_regfile import or1k_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  rf_addr_t ra_i,
   input  rf_addr_t rb_i,
   input  logic     we_i,
   input  rf_addr_t wa_i,
   input  word_t    wd_i,
   output word_t    rda_o,
   output word_t    rdb_o
);

   word_t regs [32];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we_i && wa_i != 5'd0) begin
         regs[wa_i] <= wd_i;
      end
   end

   // r0 storage stays at its reset value
   assign rda_o = regs[ra_i];
   assign rdb_o = regs[rb_i];

   // A non-zero write aimed at r0 must leave its storage at zero
   a_r0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (we_i && wa_i == 5'd0 && wd_i != '0) |=> regs[0] == '0);

endmodule

// File: hdl/or1k_ctrl.sv
// Multi-cycle controller: one Wishbone fetch, then one EXEC cycle
// Branches and jumps have no delay slot
// Any decode cause other than NONE halts the core until reset
// The Wishbone slave may stall with ack low for as long as it likes
`timescale 1ns/1ns
`include "or1k_settings.svh"

module or1k_ctrl import or1k_pkg::*; (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  insn_t    wbm_dat_i,
   input  logic     wbm_ack_i,
   input  dec_t     dec_i,
   input  word_t    alu_result_i,
   input  logic     alu_cmp_i,
   output wb_m2s_t  wbm_o,
   output insn_t    ir_o,
   output logic     rf_we_o,
   output rf_addr_t rf_wa_o,
   output word_t    rf_wd_o,
   output retire_t  retire_o,
   output logic     halt_o,
   output except_t  cause_o
);

   ctrl_state_t state;
   addr_t       pc;
   insn_t       ir;
   logic        flag;
   logic        req;
   except_t     cause;

   logic  exec_ok;
   logic  taken;
   logic  flag_next;
   addr_t pc_plus4;
   addr_t target;

   assign exec_ok   = (state == EXEC) && (dec_i.except == NONE);
   assign pc_plus4  = pc + 32'd4;
   assign target    = pc + {{4{dec_i.jbr_offset[25]}}, dec_i.jbr_offset, 2'b00};
   assign taken     = dec_i.jump || (dec_i.branch_f && flag) || (dec_i.branch_nf && !flag);
   assign flag_next = dec_i.setflag ? alu_cmp_i : flag;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state <= FETCH;
         pc    <= `OR1K_RESET_PC;
         ir    <= '0;
         flag  <= 1'b0;
         req   <= 1'b0;
         cause <= NONE;
      end else begin
         case (state)
            FETCH: begin
               if (!req) begin
                  req <= 1'b1;
               end else if (wbm_ack_i) begin
                  ir    <= wbm_dat_i;
                  req   <= 1'b0;
                  state <= EXEC;
               end
            end
            EXEC: begin
               if (dec_i.except != NONE) begin
                  cause <= dec_i.except;
                  state <= HALT;
               end else begin
                  flag  <= flag_next;
                  pc    <= taken ? target : pc_plus4;
                  // Next fetch request goes out right away
                  req   <= 1'b1;
                  state <= FETCH;
               end
            end
            default: ;  // HALT holds until reset
         endcase
      end
   end

   assign wbm_o   = '{cyc: req, stb: req, adr: pc};
   assign ir_o    = ir;

   assign rf_we_o = exec_ok && dec_i.rf_wb;
   assign rf_wa_o = dec_i.rfd;
   assign rf_wd_o = dec_i.link ? pc_plus4 : alu_result_i;

   assign retire_o = '{valid: exec_ok, pc: pc, rf_wb: rf_we_o, rd: dec_i.rfd,
                       wdata: rf_wd_o, flag: flag_next};

   assign halt_o  = (state == HALT);
   assign cause_o = cause;

   // Classic Wishbone, request held with a stable address until ack
   a_wb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wbm_o.stb && !wbm_ack_i) |=> (wbm_o.stb && $stable(wbm_o.adr)));

endmodule

// File: hdl/or1k_core_top.sv
// OR1K integer subset core, read-only Wishbone classic instruction port
// No data memory access, so the bus has no we, sel or write data
`timescale 1ns/1ns

module or1k_core_top import or1k_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_n_i,
   input  insn_t   wbm_dat_i,
   input  logic    wbm_ack_i,
   output wb_m2s_t wbm_o,
   output retire_t retire_o,
   output logic    halt_o,
   output except_t cause_o
);

   insn_t    ir;
   dec_t     dec;
   word_t    rda;
   word_t    rdb;
   word_t    alu_b;
   word_t    alu_result;
   logic     alu_cmp;
   logic     rf_we;
   rf_addr_t rf_wa;
   word_t    rf_wd;

   // Immediate forms replace operand b
   assign alu_b = dec.imm_sel ? dec.immediate : rdb;

   or1k_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .wbm_dat_i    (wbm_dat_i),
      .wbm_ack_i    (wbm_ack_i),
      .dec_i        (dec),
      .alu_result_i (alu_result),
      .alu_cmp_i    (alu_cmp),
      .wbm_o        (wbm_o),
      .ir_o         (ir),
      .rf_we_o      (rf_we),
      .rf_wa_o      (rf_wa),
      .rf_wd_o      (rf_wd),
      .retire_o     (retire_o),
      .halt_o       (halt_o),
      .cause_o      (cause_o)
   );

   or1k_decode u_decode (
      .insn_i (ir),
      .dec_o  (dec)
   );

   or1k_alu u_alu (
      .op_i     (dec.alu_op),
      .a_i      (rda),
      .b_i      (alu_b),
      .result_o (alu_result),
      .cmp_o    (alu_cmp)
   );

   or1k_regfile u_regfile (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .ra_i    (dec.rfa),
      .rb_i    (dec.rfb),
      .we_i    (rf_we),
      .wa_i    (rf_wa),
      .wd_i    (rf_wd),
      .rda_o   (rda),
      .rdb_o   (rdb)
   );

endmodule

// File: sim/tb_or1k_core.sv
// Testbench for the OR1K subset core
// Reads sim/core_stimulus.txt, so run it from the project root
// Each section of that file is run from a fresh reset
// The memory model acks after 0 to 3 random wait cycles
// Inputs change 5 ns after the rising edge and outputs are sampled there too
`timescale 1ns/1ns

module tb_or1k_core import or1k_pkg::*; ();

   localparam int MEM_WORDS = 256;

   logic    clk_i = 1'b0;
   logic    rst_n_i;
   insn_t   wbm_dat_i;
   logic    wbm_ack_i;
   wb_m2s_t wbm_o;
   retire_t retire_o;
   logic    halt_o;
   except_t cause_o;

   // Program memory of the current section
   insn_t       mem [MEM_WORDS];
   bit          mem_valid [MEM_WORDS];
   retire_t     exp_q [$];
   except_t     exp_cause;
   int          words;
   int          fd;
   int          sections;
   bit          found;
   logic [31:0] rng_state = 32'h7022f283;
   bit          busy;
   int          wait_left;

   or1k_core_top DUT (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .wbm_dat_i (wbm_dat_i),
      .wbm_ack_i (wbm_ack_i),
      .wbm_o     (wbm_o),
      .retire_o  (retire_o),
      .halt_o    (halt_o),
      .cause_o   (cause_o)
   );

   always #20 clk_i = ~clk_i;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic report_failure();
      $display("Test FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
         report_failure();
      end
   endtask

   task automatic check_cause(input except_t got, input except_t exp);
      if (got !== exp) begin
         $display("Fail at %0t ns: cause_o got %s expected %s", $time, got.name(), exp.name());
         report_failure();
      end
   endtask

   task automatic check_retire(input retire_t got, input retire_t exp);
      if (got.pc !== exp.pc) begin
         $display("Fail at %0t ns: retire_o.pc got %h expected %h", $time, got.pc, exp.pc);
         report_failure();
      end
      if (got.rf_wb !== exp.rf_wb) begin
         $display("Fail at %0t ns: retire_o.rf_wb got %b expected %b",
                  $time, got.rf_wb, exp.rf_wb);
         report_failure();
      end
      if (got.flag !== exp.flag) begin
         $display("Fail at %0t ns: retire_o.flag got %b expected %b", $time, got.flag, exp.flag);
         report_failure();
      end
      // rd and wdata carry meaning only on a register write
      if (exp.rf_wb && got.rd !== exp.rd) begin
         $display("Fail at %0t ns: retire_o.rd got %0d expected %0d", $time, got.rd, exp.rd);
         report_failure();
      end
      if (exp.rf_wb && got.wdata !== exp.wdata) begin
         $display("Fail at %0t ns: retire_o.wdata got %h expected %h",
                  $time, got.wdata, exp.wdata);
         report_failure();
      end
   endtask

   // Loads program words and expected records up to the next H line
   task automatic read_section(output bit got_section);
      logic [7:0] kind;
      int         n;
      int         code;
      string      line;
      addr_t      a;
      insn_t      d;
      addr_t      r_pc;
      logic       r_wb;
      rf_addr_t   r_rd;
      word_t      r_wd;
      logic       r_fl;
      bit         started;
      got_section = 1'b0;
      started = 1'b0;
      words = 0;
      exp_q.delete();
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_valid[i] = 1'b0;
      end
      while (!got_section) begin
         n = $fscanf(fd, " %c", kind);
         if (n != 1) begin
            if (started) begin
               $display("Stimulus file ends inside a section with no halt line");
               report_failure();
            end
            return;
         end
         case (kind)
            "#": n = $fgets(line, fd);
            "P": begin
               n = $fscanf(fd, "%h %h", a, d);
               if (n != 2 || a >= 4 * MEM_WORDS) begin
                  $display("Bad program word line in the stimulus file");
                  report_failure();
               end
               mem[a[9:2]] = d;
               mem_valid[a[9:2]] = 1'b1;
               words++;
               started = 1'b1;
            end
            "R": begin
               n = $fscanf(fd, "%h %h %h %h %h", r_pc, r_wb, r_rd, r_wd, r_fl);
               if (n != 5) begin
                  $display("Bad retire line in the stimulus file");
                  report_failure();
               end
               exp_q.push_back('{valid: 1'b1, pc: r_pc, rf_wb: r_wb, rd: r_rd,
                                 wdata: r_wd, flag: r_fl});
               started = 1'b1;
            end
            "H": begin
               n = $fscanf(fd, "%d", code);
               exp_cause = except_t'(code[1:0]);
               got_section = 1'b1;
            end
            default: begin
               $display("Unknown line kind '%c' in the stimulus file", kind);
               report_failure();
            end
         endcase
      end
   endtask

   task automatic apply_reset();
      @(posedge clk_i);
      #5;
      rst_n_i = 1'b0;
      wbm_ack_i = 1'b0;
      busy = 1'b0;
      repeat (2) @(posedge clk_i);
      #5;
      check_bit("wbm_o.cyc", wbm_o.cyc, 1'b0);
      check_bit("wbm_o.stb", wbm_o.stb, 1'b0);
      check_bit("retire_o.valid", retire_o.valid, 1'b0);
      check_bit("halt_o", halt_o, 1'b0);
      rst_n_i = 1'b1;
   endtask

   // Wishbone slave, called once per cycle at the drive point
   task automatic serve_fetch();
      wbm_ack_i = 1'b0;
      check_bit("wbm_o.cyc", wbm_o.cyc, wbm_o.stb);
      if (wbm_o.stb) begin
         if (!busy) begin
            busy = 1'b1;
            rng_state = xorshift32(rng_state);
            wait_left = rng_state[1:0];
         end
         if (wait_left == 0) begin
            if (wbm_o.adr >= 4 * MEM_WORDS || !mem_valid[wbm_o.adr[9:2]]) begin
               $display("Core fetched address %h, which holds no program word", wbm_o.adr);
               report_failure();
            end
            wbm_dat_i = mem[wbm_o.adr[9:2]];
            wbm_ack_i = 1'b1;
            busy = 1'b0;
         end else begin
            wait_left--;
         end
      end
   endtask

   task automatic run_section(input int limit);
      int      cycles;
      int      tail;
      bit      halted;
      retire_t got;
      cycles = 0;
      tail = 0;
      halted = 1'b0;
      // A few cycles past the halt make sure it stays quiet
      while (tail < 4) begin
         @(posedge clk_i);
         #5;
         cycles++;
         if (cycles > limit) begin
            $display("Timeout: the core never halted within %0d cycles", limit);
            report_failure();
         end
         got = retire_o;
         if (got.valid && halted) begin
            $display("Core retired an instruction at pc %h after it halted", got.pc);
            report_failure();
         end
         if (got.valid && exp_q.size() == 0) begin
            $display("Core retired pc %h, but no more retires were expected", got.pc);
            report_failure();
         end
         if (got.valid) begin
            check_retire(got, exp_q.pop_front());
         end
         if (halted) begin
            check_bit("halt_o", halt_o, 1'b1);
            check_cause(cause_o, exp_cause);
            tail++;
         end else if (halt_o) begin
            if (exp_q.size() != 0) begin
               $display("Core halted with %0d expected retires not seen", exp_q.size());
               report_failure();
            end
            check_cause(cause_o, exp_cause);
            halted = 1'b1;
         end else begin
            check_cause(cause_o, NONE);
         end
         serve_fetch();
      end
   endtask

   initial begin
      rst_n_i = 1'b0;
      wbm_ack_i = 1'b0;
      wbm_dat_i = '0;
      busy = 1'b0;
      wait_left = 0;
      sections = 0;
      fd = $fopen("sim/core_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Cannot open sim/core_stimulus.txt");
         report_failure();
      end
      read_section(found);
      while (found) begin
         apply_reset();
         // Worst case fetch plus EXEC is 6 cycles per word
         run_section(words * 6 + 50);
         sections++;
         read_section(found);
      end
      $fclose(fd);
      if (sections == 0) begin
         $display("The stimulus file holds no complete section");
         report_failure();
      end else begin
         $display("Test OK");
         $finish;
      end
   end

endmodule

// File: sim/core_stimulus.txt
# P <address> <instruction>            program word, hex
# R <pc> <rf_wb> <rd> <wdata> <flag>   expected retire in order, hex; rd, wdata unused if rf_wb 0
# H <cause>                            halt cause, 1 illegal, 2 sys, 3 trap; closes a section
# Section 1: ALU ops, r0, setflag with branches, jumps, halt on a load
P 100 9C20FFFB  # l.addi r1,r0,-5
P 104 A4418F0F  # l.andi r2,r1,0x8f0f
P 108 A8608001  # l.ori r3,r0,0x8001
P 10C AC81FFFF  # l.xori r4,r1,-1
P 110 18A01234  # l.movhi r5,0x1234
P 114 E0C52000  # l.add r6,r5,r4
P 118 E0E02002  # l.sub r7,r0,r4
P 11C E1021803  # l.and r8,r2,r3
P 120 E1451804  # l.or r10,r5,r3
P 124 E0062805  # l.xor r0,r6,r5
P 128 E1602000  # l.add r11,r0,r4
P 12C E40B2000  # l.sfeq r11,r4
P 130 10000003  # l.bf 3, taken
P 134 9D800001  # skipped
P 138 9D800001  # skipped
P 13C 0C000002  # l.bnf 2, not taken
P 140 BC240004  # l.sfnei r4,4
P 144 10000002  # l.bf 2, not taken
P 148 0C000002  # l.bnf 2, taken
P 14C 9D800001  # skipped
P 150 00000003  # l.j 3
P 154 9D800001  # skipped
P 158 9D800001  # skipped
P 15C 04000002  # l.jal 2
P 160 9D800001  # skipped
P 164 A9890000  # l.ori r12,r9,0
P 168 15000000  # l.nop
P 16C 84220000  # l.lwz r1,0(r2)
P 170 9D800001  # never reached
R 100 1 01 FFFFFFFB 0
R 104 1 02 00008F0B 0
R 108 1 03 00008001 0
R 10C 1 04 00000004 0
R 110 1 05 12340000 0
R 114 1 06 12340004 0
R 118 1 07 FFFFFFFC 0
R 11C 1 08 00008001 0
R 120 1 0A 12348001 0
R 124 1 00 00000004 0
R 128 1 0B 00000004 0
R 12C 0 00 00000000 1
R 130 0 00 00000000 1
R 13C 0 00 00000000 1
R 140 0 00 00000000 0
R 144 0 00 00000000 0
R 148 0 00 00000000 0
R 150 0 00 00000000 0
R 15C 1 09 00000160 0
R 164 1 0C 00000160 0
R 168 0 00 00000000 0
H 1
# Section 2: registers cleared by reset, halt on l.sys
P 100 9C207FFF  # l.addi r1,r0,0x7fff
P 104 E0416000  # l.add r2,r1,r12
P 108 20000001  # l.sys 1
P 10C 9D800001  # never reached
R 100 1 01 00007FFF 0
R 104 1 02 00007FFF 0
H 2

// File: all.f
+incdir+common
common/or1k_pkg.sv
hdl/or1k_decode.sv
hdl/or1k_alu.sv
hdl/or1k_regfile.sv
hdl/or1k_ctrl.sv
hdl/or1k_core_top.sv
sim/tb_or1k_core.sv

// File: Bender.yml
package:
  name: or1k_core

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/or1k_pkg.sv
      - hdl/or1k_decode.sv
      - hdl/or1k_alu.sv
      - hdl/or1k_regfile.sv
      - hdl/or1k_ctrl.sv
      - hdl/or1k_core_top.sv
  - target: simulation
    files:
      - sim/tb_or1k_core.sv
